// ==== Bender.yml ====
package:
  name: vread

sources:
  - common/vread_pkg.sv
  - common/vread_cfg_if.sv
  - source/vread_config.sv
  - fetch/vread_fetch.sv
  - source/vread_addr_gen.sv
  - source/vread_buffer.sv
  - source/vread_output.sv
  - source/vread_top.sv
  - target: test
    files:
      - dv/vread_bus_mem.sv
      - dv/vread_tb.sv

// ==== common/vread_cfg_if.sv ====
interface vread_cfg_if;

   logic [vread_pkg::BUS_ADDR_W-1:0] ext_addr;
   logic [vread_pkg::AMOUNT_W-1:0]   amount;
   logic                             fetch_en;
   logic                             ping_pong;
   // half being read by the output phase
   logic                             pp_state;

   // output address generator fields
   logic [vread_pkg::OUT_ADDR_W-1:0] start;
   logic [vread_pkg::OUT_ADDR_W-1:0] incr;
   logic [vread_pkg::PERIOD_W-1:0]   per;
   logic [vread_pkg::PERIOD_W-1:0]   duty;
   logic [vread_pkg::ITER_W-1:0]     iter;
   logic [vread_pkg::OUT_ADDR_W-1:0] shift;
   logic [vread_pkg::OUT_ADDR_W-1:0] incr2;
   logic [vread_pkg::ITER_W-1:0]     iter2;
   logic [vread_pkg::DELAY_W-1:0]    delay;

   modport cfg (output ext_addr, amount, fetch_en, ping_pong, pp_state,
                start, incr, per, duty, iter, shift, incr2, iter2, delay);
   modport fetch (input ext_addr, amount, fetch_en, ping_pong);
   modport agen (input ping_pong, start, incr, per, duty, iter, shift, incr2, iter2, delay);

endinterface

// ==== common/vread_pkg.sv ====
package vread_pkg;

   // data bus side
   localparam int BUS_DATA_W = 32;
   localparam int BUS_ADDR_W = 32;

   // log2 of the bytes in one bus word
   localparam int BYTE_SHIFT = 2;

   // one output value is half a bus word
   localparam int DATA_W = 16;

   // buffer word address, top bit picks the ping-pong half
   localparam int BUF_ADDR_W = 8;
   localparam int BUF_WORDS = 2 ** BUF_ADDR_W;

   // output address counts half-words
   localparam int OUT_ADDR_W = BUF_ADDR_W + 1;

   // word count of one transfer, can cover the whole buffer
   localparam int AMOUNT_W = BUF_ADDR_W + 1;

   // burst length in beats
   localparam int LEN_W = 8;

   // longest burst the fetch engine issues
   localparam int BURST_MAX = 16;

   // period and duty of the inner cycle loop
   localparam int PERIOD_W = 6;

   // inner and outer loop counts
   localparam int ITER_W = 8;

   // start delay of the output phase
   localparam int DELAY_W = 5;

endpackage

// ==== dv/vread_bus_mem.sv ====
module vread_bus_mem (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             stall_en_i,
   input  logic                             valid_i,
   output logic                             ready_o,
   input  logic [vread_pkg::BUS_ADDR_W-1:0] addr_i,
   input  logic [vread_pkg::LEN_W-1:0]      len_i,
   output logic [vread_pkg::BUS_DATA_W-1:0] rdata_o,
   output logic                             last_o
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_WORDS = 1024;
   localparam int LOG_DEPTH = 512;

   logic [vread_pkg::BUS_DATA_W-1:0] mem [MEM_WORDS];
   // one entry per finished burst
   logic [vread_pkg::BUS_ADDR_W-1:0] log_addr [LOG_DEPTH];
   logic [vread_pkg::LEN_W-1:0]      log_len [LOG_DEPTH];
   int                               log_cnt;
   int                               beat_cnt;
   int                               word_idx;

   // byte address wraps onto the word array
   assign word_idx = ((addr_i >> vread_pkg::BYTE_SHIFT) + beat_cnt) % MEM_WORDS;
   assign rdata_o  = mem[word_idx];
   assign last_o   = valid_i && (beat_cnt == int'(len_i) - 1);

   task automatic fill_random();
      for (int k = 0; k < MEM_WORDS; k++) begin
         mem[k] = $urandom;
      end
   endtask

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_o  <= 1'b0;
         beat_cnt <= 0;
         log_cnt  <= 0;
      end else begin
         // roughly one stall in four when stalls are on
         ready_o <= !stall_en_i || (($urandom % 4) != 0);
         if (valid_i && ready_o) begin
            if (last_o) begin
               beat_cnt                     <= 0;
               log_addr[log_cnt % LOG_DEPTH] <= addr_i;
               log_len[log_cnt % LOG_DEPTH]  <= len_i;
               log_cnt                      <= log_cnt + 1;
            end else begin
               beat_cnt <= beat_cnt + 1;
            end
         end
      end
   end

endmodule

// ==== dv/vread_tb.sv ====
module vread_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 5000;
   localparam int MEM_WORDS  = 1024;
   localparam int LOG_DEPTH  = 512;

   logic                             clk;
   logic                             rst;
   logic                             run;
   logic                             enabled;
   logic                             ping_pong;
   logic [vread_pkg::BUS_ADDR_W-1:0] ext_addr;
   logic [vread_pkg::AMOUNT_W-1:0]   amount;
   logic [vread_pkg::OUT_ADDR_W-1:0] start;
   logic [vread_pkg::OUT_ADDR_W-1:0] incr;
   logic [vread_pkg::PERIOD_W-1:0]   per;
   logic [vread_pkg::PERIOD_W-1:0]   duty;
   logic [vread_pkg::ITER_W-1:0]     iter;
   logic [vread_pkg::OUT_ADDR_W-1:0] shift;
   logic [vread_pkg::OUT_ADDR_W-1:0] incr2;
   logic [vread_pkg::ITER_W-1:0]     iter2;
   logic [vread_pkg::DELAY_W-1:0]    delay;
   logic                             done;
   logic                             db_valid;
   logic                             db_ready;
   logic [vread_pkg::BUS_ADDR_W-1:0] db_addr;
   logic [vread_pkg::LEN_W-1:0]      db_len;
   logic [vread_pkg::BUS_DATA_W-1:0] db_rdata;
   logic                             db_last;
   logic [vread_pkg::DATA_W-1:0]     out;
   logic                             out_valid;
   logic                             stall_en;

   // configuration of the next run
   logic                             nx_en;
   logic                             nx_pp;
   logic [vread_pkg::BUS_ADDR_W-1:0] nx_ext;
   logic [vread_pkg::AMOUNT_W-1:0]   nx_amount;
   logic [vread_pkg::OUT_ADDR_W-1:0] nx_start;
   logic [vread_pkg::OUT_ADDR_W-1:0] nx_incr;
   logic [vread_pkg::PERIOD_W-1:0]   nx_per;
   logic [vread_pkg::PERIOD_W-1:0]   nx_duty;
   logic [vread_pkg::ITER_W-1:0]     nx_iter;
   logic [vread_pkg::OUT_ADDR_W-1:0] nx_shift;
   logic [vread_pkg::OUT_ADDR_W-1:0] nx_incr2;
   logic [vread_pkg::ITER_W-1:0]     nx_iter2;
   logic [vread_pkg::DELAY_W-1:0]    nx_delay;

   // reference model of the buffer and ping-pong half
   logic [vread_pkg::BUS_DATA_W-1:0] model_buf [vread_pkg::BUF_WORDS];
   logic                             model_pp;
   logic [vread_pkg::DATA_W-1:0]     exp_q [$];
   logic [vread_pkg::DATA_W-1:0]     got_q [$];

   int value_errors;
   int burst_errors;
   int done_errors;
   int timeouts;

   vread_top vread_top_inst (
      .clk, .rst,
      .run_i           (run),
      .enabled_i       (enabled),
      .ping_pong_i     (ping_pong),
      .ext_addr_i      (ext_addr),
      .amount_i        (amount),
      .start_i         (start),
      .incr_i          (incr),
      .per_i           (per),
      .duty_i          (duty),
      .iter_i          (iter),
      .shift_i         (shift),
      .incr2_i         (incr2),
      .iter2_i         (iter2),
      .delay_i         (delay),
      .done_o          (done),
      .databus_valid_o (db_valid),
      .databus_ready_i (db_ready),
      .databus_addr_o  (db_addr),
      .databus_len_o   (db_len),
      .databus_rdata_i (db_rdata),
      .databus_last_i  (db_last),
      .out_o           (out),
      .out_valid_o     (out_valid)
   );

   vread_bus_mem bus_mem_inst (
      .clk, .rst,
      .stall_en_i (stall_en),
      .valid_i    (db_valid),
      .ready_o    (db_ready),
      .addr_i     (db_addr),
      .len_i      (db_len),
      .rdata_o    (db_rdata),
      .last_o     (db_last)
   );

   always #10 clk = ~clk;

   // collect every output value
   always @(posedge clk) begin
      if (!rst && out_valid) begin
         got_q.push_back(out);
      end
   end

   task automatic check_value(input string name, input logic [vread_pkg::DATA_W-1:0] exp_val,
                              input logic [vread_pkg::DATA_W-1:0] act_val);
      if (act_val !== exp_val) begin
         $display("error %s: expected %h, actual %h", name, exp_val, act_val);
         value_errors++;
      end
   endtask

   task automatic check_burst(input string name,
                              input logic [vread_pkg::BUS_ADDR_W-1:0] exp_addr,
                              input logic [vread_pkg::LEN_W-1:0] exp_len,
                              input logic [vread_pkg::BUS_ADDR_W-1:0] act_addr,
                              input logic [vread_pkg::LEN_W-1:0] act_len);
      if (act_addr !== exp_addr || act_len !== exp_len) begin
         $display("error %s: expected addr %h len %0d, actual addr %h len %0d",
                  name, exp_addr, exp_len, act_addr, act_len);
         burst_errors++;
      end
   endtask

   task automatic check_done(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         $display("error %s: expected %b, actual %b", name, exp_val, act_val);
         done_errors++;
      end
   endtask

   task automatic wait_done(input string name);
      int cycles;
      cycles = 0;
      while (!done && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("timeout in %s: done did not rise within %0d cycles", name, WAIT_LIMIT);
         timeouts++;
      end
   endtask

   // half-word at an output address in the model buffer
   function automatic logic [vread_pkg::DATA_W-1:0] expected_half(input int a);
      int                               w;
      logic [vread_pkg::BUS_DATA_W-1:0] word;
      if (nx_pp) begin
         w = (model_pp ? 128 : 0) + (a / 2) % 128;
      end else begin
         w = (a / 2) % 256;
      end
      word = model_buf[w];
      if (a % 2 == 1) begin
         return word[31:16];
      end
      return word[15:0];
   endfunction

   task automatic set_fetch(input int words);
      nx_en     = 1'b1;
      nx_pp     = 1'b0;
      nx_ext    = $urandom & 32'hffff_fffc;
      nx_amount = words;
      // no output so that reads and writes never overlap
      nx_iter   = 0;
      nx_iter2  = 1;
      nx_per    = 1;
      nx_duty   = 1;
      nx_start  = 0;
      nx_incr   = 0;
      nx_shift  = 0;
      nx_incr2  = 0;
      nx_delay  = $urandom % 32;
   endtask

   task automatic set_linear(input int words);
      nx_en    = 1'b0;
      nx_pp    = 1'b0;
      nx_start = 0;
      nx_incr  = 1;
      nx_per   = 2;
      nx_duty  = 2;
      nx_shift = 2;
      nx_incr2 = 256;
      nx_iter  = (words == 256) ? 128 : words;
      nx_iter2 = (words == 256) ? 2 : 1;
      nx_delay = $urandom % 32;
   endtask

   task automatic set_pattern();
      nx_en    = 1'b0;
      nx_pp    = 1'b0;
      nx_start = $urandom % 512;
      nx_incr  = $urandom % 512;
      nx_shift = $urandom % 512;
      nx_incr2 = $urandom % 512;
      nx_per   = 1 + $urandom % 12;
      nx_duty  = $urandom % (nx_per + 1);
      nx_iter  = 1 + $urandom % 8;
      nx_iter2 = 1 + $urandom % 4;
      nx_delay = $urandom % 32;
   endtask

   // kept below 256 so every read stays in one half
   task automatic set_pingpong();
      nx_en     = 1'b1;
      nx_pp     = 1'b1;
      nx_ext    = $urandom & 32'hffff_fffc;
      nx_amount = 128;
      nx_start  = $urandom % 64;
      nx_incr   = $urandom % 4;
      nx_per    = 1 + $urandom % 8;
      nx_duty   = $urandom % (nx_per + 1);
      nx_iter   = 1 + $urandom % 8;
      nx_shift  = $urandom % 16;
      nx_iter2  = 1 + $urandom % 4;
      nx_incr2  = $urandom % 16;
      nx_delay  = $urandom % 32;
   endtask

   task automatic execute_run(input string name, input bit check_vals);
      int                               log_start;
      int                               nbursts;
      int                               a;
      int                               idx;
      int                               left;
      logic [vread_pkg::BUS_ADDR_W-1:0] exp_addr;
      logic [vread_pkg::LEN_W-1:0]      exp_len;
      model_pp = nx_pp ? ~model_pp : 1'b0;
      exp_q.delete();
      for (int o = 0; o < nx_iter2; o++) begin
         for (int i = 0; i < nx_iter; i++) begin
            for (int c = 0; c < nx_per && c < nx_duty; c++) begin
               a = (nx_start + o * nx_incr2 + i * nx_shift + c * nx_incr) %
                   (1 << vread_pkg::OUT_ADDR_W);
               exp_q.push_back(expected_half(a));
            end
         end
      end
      log_start = bus_mem_inst.log_cnt;
      @(posedge clk);
      run       <= 1'b1;
      enabled   <= nx_en;
      ping_pong <= nx_pp;
      ext_addr  <= nx_ext;
      amount    <= nx_amount;
      start     <= nx_start;
      incr      <= nx_incr;
      per       <= nx_per;
      duty      <= nx_duty;
      iter      <= nx_iter;
      shift     <= nx_shift;
      incr2     <= nx_incr2;
      iter2     <= nx_iter2;
      delay     <= nx_delay;
      @(posedge clk);
      run <= 1'b0;
      // done flags cleared on the run edge show up one cycle later
      @(posedge clk);
      check_done({name, " done after run"}, 1'b0, done);
      wait_done(name);
      if (nx_en) begin
         nbursts = (nx_amount + vread_pkg::BURST_MAX - 1) / vread_pkg::BURST_MAX;
         if (bus_mem_inst.log_cnt - log_start != nbursts) begin
            $display("error %s burst count: expected %0d, actual %0d",
                     name, nbursts, bus_mem_inst.log_cnt - log_start);
            burst_errors++;
         end else begin
            for (int k = 0; k < nbursts; k++) begin
               exp_addr = nx_ext + k * (vread_pkg::BURST_MAX << vread_pkg::BYTE_SHIFT);
               left     = nx_amount - k * vread_pkg::BURST_MAX;
               exp_len  = (left > vread_pkg::BURST_MAX) ? vread_pkg::BURST_MAX : left;
               idx      = (log_start + k) % LOG_DEPTH;
               check_burst($sformatf("%s burst %0d", name, k), exp_addr, exp_len,
                           bus_mem_inst.log_addr[idx], bus_mem_inst.log_len[idx]);
            end
         end
      end
      if (got_q.size() != exp_q.size()) begin
         $display("error %s value count: expected %0d, actual %0d",
                  name, exp_q.size(), got_q.size());
         value_errors++;
      end else if (check_vals) begin
         for (int k = 0; k < exp_q.size(); k++) begin
            check_value($sformatf("%s value %0d", name, k), exp_q[k], got_q[k]);
         end
      end
      got_q.delete();
      // words fetched in this run land in the model buffer
      if (nx_en) begin
         for (int j = 0; j < nx_amount; j++) begin
            idx = ((nx_ext >> vread_pkg::BYTE_SHIFT) + j) % MEM_WORDS;
            a   = nx_pp ? ((model_pp ? 0 : 128) + j % 128) : j % 256;
            model_buf[a] = bus_mem_inst.mem[idx];
         end
      end
   endtask

   initial begin
      int unsigned seed;
      int          words;
      seed = 32'h40d4;
      void'($urandom(seed));
      clk          = 1'b0;
      rst          = 1'b1;
      run          = 1'b0;
      enabled      = 1'b0;
      ping_pong    = 1'b0;
      ext_addr     = '0;
      amount       = '0;
      start        = '0;
      incr         = '0;
      per          = '0;
      duty         = '0;
      iter         = '0;
      shift        = '0;
      incr2        = '0;
      iter2        = '0;
      delay        = '0;
      stall_en     = 1'b0;
      model_pp     = 1'b0;
      value_errors = 0;
      burst_errors = 0;
      done_errors  = 0;
      timeouts     = 0;
      bus_mem_inst.fill_random();
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_done("reset done", 1'b1, done);
      check_done("reset databus valid", 1'b0, db_valid);
      check_done("reset out valid", 1'b0, out_valid);

      // partial fetch then read back in order
      words = 1 + $urandom % 255;
      set_fetch(words);
      execute_run("fetch partial", 1'b1);
      set_linear(words);
      execute_run("linear partial", 1'b1);

      // whole buffer with a stalling bus
      stall_en <= 1'b1;
      set_fetch(256);
      execute_run("fetch full", 1'b1);
      set_linear(256);
      execute_run("linear full", 1'b1);

      for (int r = 0; r < 6; r++) begin
         set_pattern();
         execute_run($sformatf("pattern %0d", r), 1'b1);
      end
      set_pattern();
      nx_iter = 0;
      execute_run("pattern zero count", 1'b1);

      // first ping-pong run reads a half that is not checked
      for (int r = 0; r < 4; r++) begin
         set_pingpong();
         execute_run($sformatf("pingpong %0d", r), r != 0);
      end

      $display("value errors %0d, burst errors %0d, done errors %0d, timeouts %0d",
               value_errors, burst_errors, done_errors, timeouts);
      if (value_errors + burst_errors + done_errors + timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== fetch/vread_fetch.sv ====
module vread_fetch (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   vread_cfg_if.fetch                       cfg,
   output logic                             databus_valid_o,
   input  logic                             databus_ready_i,
   output logic [vread_pkg::BUS_ADDR_W-1:0] databus_addr_o,
   output logic [vread_pkg::LEN_W-1:0]      databus_len_o,
   input  logic [vread_pkg::BUS_DATA_W-1:0] databus_rdata_i,
   input  logic                             databus_last_i,
   output logic                             wr_en_o,
   output logic [vread_pkg::BUF_ADDR_W-1:0] wr_addr_o,
   output logic [vread_pkg::BUS_DATA_W-1:0] wr_data_o,
   output logic                             done_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BURST,
      ST_GAP
   } state_t;

   state_t                           state_q;
   // words covered by finished bursts
   logic [vread_pkg::AMOUNT_W-1:0]   bwords_q;
   // running word index of accepted beats
   logic [vread_pkg::AMOUNT_W-1:0]   widx_q;
   logic [vread_pkg::AMOUNT_W-1:0]   remaining;
   logic [vread_pkg::BUS_ADDR_W-1:0] byte_off;
   logic                             beat;

   assign remaining = cfg.amount - bwords_q;
   assign byte_off  = {{(vread_pkg::BUS_ADDR_W-vread_pkg::AMOUNT_W-vread_pkg::BYTE_SHIFT){1'b0}},
                       bwords_q, {vread_pkg::BYTE_SHIFT{1'b0}}};

   // addr and len only move between bursts
   assign databus_addr_o = cfg.ext_addr + byte_off;
   always_comb begin
      if (remaining > vread_pkg::BURST_MAX) begin
         databus_len_o = vread_pkg::BURST_MAX[vread_pkg::LEN_W-1:0];
      end else begin
         databus_len_o = remaining[vread_pkg::LEN_W-1:0];
      end
   end

   assign databus_valid_o = (state_q == ST_BURST) && cfg.fetch_en && (remaining != '0);
   assign beat            = databus_valid_o && databus_ready_i;

   // every beat goes straight into the buffer
   assign wr_en_o   = beat;
   assign wr_addr_o = widx_q[vread_pkg::BUF_ADDR_W-1:0];
   assign wr_data_o = databus_rdata_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q  <= ST_IDLE;
         bwords_q <= '0;
         widx_q   <= '0;
         done_o   <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (run_i) begin
            state_q  <= ST_BURST;
            bwords_q <= '0;
            widx_q   <= '0;
         end else begin
            case (state_q)
               ST_BURST: begin
                  if (!databus_valid_o) begin
                     // nothing to move in this run
                     state_q <= ST_IDLE;
                     done_o  <= 1'b1;
                  end else if (beat) begin
                     widx_q <= widx_q + 1'b1;
                     if (databus_last_i) begin
                        bwords_q <= bwords_q +
                                    {{(vread_pkg::AMOUNT_W-vread_pkg::LEN_W){1'b0}}, databus_len_o};
                        state_q  <= ST_GAP;
                     end
                  end
               end
               ST_GAP: begin
                  if (remaining == '0) begin
                     state_q <= ST_IDLE;
                     done_o  <= 1'b1;
                  end else begin
                     state_q <= ST_BURST;
                  end
               end
               default: state_q <= ST_IDLE;
            endcase
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !(databus_ready_i && databus_last_i) |=>
         databus_valid_o && $stable(databus_addr_o) && $stable(databus_len_o));

   // ping-pong transfers must fit in one half
   assert property (@(posedge clk) disable iff (rst)
      wr_en_o && cfg.ping_pong |-> widx_q[vread_pkg::AMOUNT_W-1:vread_pkg::BUF_ADDR_W-1] == '0);

endmodule

// ==== source/vread_addr_gen.sv ====
module vread_addr_gen (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   vread_cfg_if.agen                        cfg,
   output logic                             rd_en_o,
   output logic [vread_pkg::OUT_ADDR_W-1:0] rd_addr_o,
   output logic                             done_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_RUN
   } state_t;

   state_t                           state_q;
   logic [vread_pkg::DELAY_W-1:0]    dcnt_q;
   logic [vread_pkg::PERIOD_W-1:0]   c_q;
   logic [vread_pkg::ITER_W-1:0]     i_q;
   logic [vread_pkg::ITER_W-1:0]     o_q;
   // address offsets of each loop level
   logic [vread_pkg::OUT_ADDR_W-1:0] acc_c_q;
   logic [vread_pkg::OUT_ADDR_W-1:0] acc_i_q;
   logic [vread_pkg::OUT_ADDR_W-1:0] acc_o_q;
   logic                             zero_cnt;
   logic                             active;
   logic                             last_c;
   logic                             last_i;
   logic                             last_o;

   assign zero_cnt = (cfg.per == '0) || (cfg.iter == '0) || (cfg.iter2 == '0);

   // the last delay cycle already counts as the first loop cycle
   assign active = !zero_cnt &&
                   ((state_q == ST_RUN) || (state_q == ST_WAIT && dcnt_q == cfg.delay));

   assign last_c = (c_q == cfg.per - 1'b1);
   assign last_i = (i_q == cfg.iter - 1'b1);
   assign last_o = (o_q == cfg.iter2 - 1'b1);

   assign rd_en_o   = active && (c_q < cfg.duty);
   assign rd_addr_o = cfg.start + acc_o_q + acc_i_q + acc_c_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
         dcnt_q  <= '0;
         c_q     <= '0;
         i_q     <= '0;
         o_q     <= '0;
         acc_c_q <= '0;
         acc_i_q <= '0;
         acc_o_q <= '0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (run_i) begin
            state_q <= ST_WAIT;
            dcnt_q  <= '0;
            c_q     <= '0;
            i_q     <= '0;
            o_q     <= '0;
            acc_c_q <= '0;
            acc_i_q <= '0;
            acc_o_q <= '0;
         end else if (state_q == ST_WAIT && zero_cnt) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b1;
         end else if (active) begin
            state_q <= ST_RUN;
            if (!last_c) begin
               c_q     <= c_q + 1'b1;
               acc_c_q <= acc_c_q + cfg.incr;
            end else begin
               c_q     <= '0;
               acc_c_q <= '0;
               if (!last_i) begin
                  i_q     <= i_q + 1'b1;
                  acc_i_q <= acc_i_q + cfg.shift;
               end else begin
                  i_q     <= '0;
                  acc_i_q <= '0;
                  if (!last_o) begin
                     o_q     <= o_q + 1'b1;
                     acc_o_q <= acc_o_q + cfg.incr2;
                  end else begin
                     state_q <= ST_IDLE;
                     done_o  <= 1'b1;
                  end
               end
            end
         end else if (state_q == ST_WAIT) begin
            dcnt_q <= dcnt_q + 1'b1;
         end
      end
   end

   // reads in ping-pong mode stay below the half boundary
   assert property (@(posedge clk) disable iff (rst)
      rd_en_o && cfg.ping_pong |-> !rd_addr_o[vread_pkg::OUT_ADDR_W-1]);

endmodule

// ==== source/vread_buffer.sv ====
module vread_buffer (
   input  logic                             clk,
   input  logic                             wr_en_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] wr_addr_i,
   input  logic [vread_pkg::BUS_DATA_W-1:0] wr_data_i,
   input  logic                             rd_en_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] rd_addr_i,
   output logic [vread_pkg::BUS_DATA_W-1:0] rd_data_o
);

   logic [vread_pkg::BUS_DATA_W-1:0] mem [vread_pkg::BUF_WORDS];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read register holds its word until the next read
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== source/vread_config.sv ====
module vread_config (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   input  logic                             enabled_i,
   input  logic                             ping_pong_i,
   input  logic [vread_pkg::BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [vread_pkg::AMOUNT_W-1:0]   amount_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] start_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] incr_i,
   input  logic [vread_pkg::PERIOD_W-1:0]   per_i,
   input  logic [vread_pkg::PERIOD_W-1:0]   duty_i,
   input  logic [vread_pkg::ITER_W-1:0]     iter_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] shift_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] incr2_i,
   input  logic [vread_pkg::ITER_W-1:0]     iter2_i,
   input  logic [vread_pkg::DELAY_W-1:0]    delay_i,
   input  logic                             fetch_done_i,
   input  logic                             agen_done_i,
   output logic                             done_o,
   vread_cfg_if.cfg                         cfg
);

   logic fetch_done_q;
   logic agen_done_q;

   // run state and ping-pong half
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg.fetch_en  <= 1'b0;
         cfg.ping_pong <= 1'b0;
         cfg.pp_state  <= 1'b0;
      end else if (run_i) begin
         cfg.fetch_en  <= enabled_i;
         cfg.ping_pong <= ping_pong_i;
         cfg.pp_state  <= ping_pong_i ? ~cfg.pp_state : 1'b0;
      end
   end

   // address and loop fields, only meaningful after a run
   always_ff @(posedge clk) begin
      if (run_i) begin
         cfg.ext_addr <= ext_addr_i;
         cfg.amount   <= amount_i;
         cfg.start    <= start_i;
         cfg.incr     <= incr_i;
         cfg.per      <= per_i;
         cfg.duty     <= duty_i;
         cfg.iter     <= iter_i;
         cfg.shift    <= shift_i;
         cfg.incr2    <= incr2_i;
         cfg.iter2    <= iter2_i;
         cfg.delay    <= delay_i;
      end
   end

   // sticky done flags, a disabled fetch is done from the start
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetch_done_q <= 1'b1;
         agen_done_q  <= 1'b1;
      end else if (run_i) begin
         fetch_done_q <= ~enabled_i;
         agen_done_q  <= 1'b0;
      end else begin
         if (fetch_done_i) fetch_done_q <= 1'b1;
         if (agen_done_i) agen_done_q <= 1'b1;
      end
   end

   assign done_o = fetch_done_q & agen_done_q;

   // a new run only once both engines have finished
   assert property (@(posedge clk) disable iff (rst) run_i |-> done_o);

endmodule

// ==== source/vread_output.sv ====
module vread_output (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             rd_en_i,
   input  logic                             half_sel_i,
   input  logic [vread_pkg::BUS_DATA_W-1:0] rd_data_i,
   output logic [vread_pkg::DATA_W-1:0]     out_o,
   output logic                             out_valid_o
);

   logic sel_q;
   logic valid_q;

   // follow the read by one cycle, sel only moves with a read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sel_q   <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= rd_en_i;
         if (rd_en_i) begin
            sel_q <= half_sel_i;
         end
      end
   end

   // odd half-word address picks the upper lane
   always_comb begin
      if (sel_q) begin
         out_o = rd_data_i[vread_pkg::BUS_DATA_W-1 -: vread_pkg::DATA_W];
      end else begin
         out_o = rd_data_i[vread_pkg::DATA_W-1:0];
      end
   end

   assign out_valid_o = valid_q;

endmodule

// ==== source/vread_top.sv ====
module vread_top (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   input  logic                             enabled_i,
   input  logic                             ping_pong_i,
   input  logic [vread_pkg::BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [vread_pkg::AMOUNT_W-1:0]   amount_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] start_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] incr_i,
   input  logic [vread_pkg::PERIOD_W-1:0]   per_i,
   input  logic [vread_pkg::PERIOD_W-1:0]   duty_i,
   input  logic [vread_pkg::ITER_W-1:0]     iter_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] shift_i,
   input  logic [vread_pkg::OUT_ADDR_W-1:0] incr2_i,
   input  logic [vread_pkg::ITER_W-1:0]     iter2_i,
   input  logic [vread_pkg::DELAY_W-1:0]    delay_i,
   output logic                             done_o,
   output logic                             databus_valid_o,
   input  logic                             databus_ready_i,
   output logic [vread_pkg::BUS_ADDR_W-1:0] databus_addr_o,
   output logic [vread_pkg::LEN_W-1:0]      databus_len_o,
   input  logic [vread_pkg::BUS_DATA_W-1:0] databus_rdata_i,
   input  logic                             databus_last_i,
   output logic [vread_pkg::DATA_W-1:0]     out_o,
   output logic                             out_valid_o
);

   logic                             fetch_done;
   logic                             agen_done;
   logic                             wr_en;
   logic [vread_pkg::BUF_ADDR_W-1:0] wr_addr;
   logic [vread_pkg::BUS_DATA_W-1:0] wr_data;
   logic [vread_pkg::BUF_ADDR_W-1:0] buf_wr_addr;
   logic                             rd_en;
   logic [vread_pkg::OUT_ADDR_W-1:0] rd_addr;
   logic [vread_pkg::BUF_ADDR_W-1:0] buf_rd_addr;
   logic [vread_pkg::BUS_DATA_W-1:0] rd_data;

   vread_cfg_if cfg_if ();

   vread_config vread_config_inst (
      .clk, .rst, .run_i, .enabled_i, .ping_pong_i, .ext_addr_i, .amount_i,
      .start_i, .incr_i, .per_i, .duty_i, .iter_i, .shift_i, .incr2_i, .iter2_i, .delay_i,
      .fetch_done_i (fetch_done),
      .agen_done_i  (agen_done),
      .done_o,
      .cfg          (cfg_if.cfg)
   );

   vread_fetch vread_fetch_inst (
      .clk, .rst, .run_i,
      .cfg (cfg_if.fetch),
      .databus_valid_o, .databus_ready_i, .databus_addr_o, .databus_len_o,
      .databus_rdata_i, .databus_last_i,
      .wr_en_o   (wr_en),
      .wr_addr_o (wr_addr),
      .wr_data_o (wr_data),
      .done_o    (fetch_done)
   );

   vread_addr_gen vread_addr_gen_inst (
      .clk, .rst, .run_i,
      .cfg       (cfg_if.agen),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .done_o    (agen_done)
   );

   // fetch fills the half that the output phase is not reading
   assign buf_wr_addr = cfg_if.ping_pong ?
                        {~cfg_if.pp_state, wr_addr[vread_pkg::BUF_ADDR_W-2:0]} : wr_addr;
   assign buf_rd_addr = cfg_if.ping_pong ?
                        {cfg_if.pp_state, rd_addr[vread_pkg::OUT_ADDR_W-2:1]} :
                        rd_addr[vread_pkg::OUT_ADDR_W-1:1];

   vread_buffer vread_buffer_inst (
      .clk,
      .wr_en_i   (wr_en),
      .wr_addr_i (buf_wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (buf_rd_addr),
      .rd_data_o (rd_data)
   );

   vread_output vread_output_inst (
      .clk, .rst,
      .rd_en_i    (rd_en),
      .half_sel_i (rd_addr[0]),
      .rd_data_i  (rd_data),
      .out_o, .out_valid_o
   );

endmodule

// ==== tb.f ====
common/vread_pkg.sv
common/vread_cfg_if.sv
source/vread_config.sv
fetch/vread_fetch.sv
source/vread_addr_gen.sv
source/vread_buffer.sv
source/vread_output.sv
source/vread_top.sv
dv/vread_bus_mem.sv
dv/vread_tb.sv
